// ==== src.f ====
verilog/lsqCfgPkg.sv
verilog/memOpPkg.sv
verilog/lsqEntryIf.sv
verilog/lsqStorage.sv
verilog/storeForward.sv
verilog/readyPick.sv
verilog/lsqIssue.sv
verilog/loadStoreQueue.sv
verif/tbLoadStoreQueue.sv

// ==== Makefile ====
TOP = tbLoadStoreQueue

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal -f src.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "^Verification passed$$"

clean:
	rm -rf obj_dir

// ==== verif/tbLoadStoreQueue.sv ====
`timescale 1ns/1ps

module tbLoadStoreQueue import lsqCfgPkg::*; ();

    localparam int scriptCycles = 300;   // directed part, with slack
    localparam int randCycles   = 800;
    localparam int cycleLimit   = scriptCycles + randCycles + 200;

    logic        clk, rstn, memRead, memWrite, storeSize, addrValid, retire1, retire2;
    logic [31:0] pcDis, swData, pcLsu, addressLsu, pcRet1, pcRet2;
    logic        lsqFull, issueValid, loadStore, storeSizeOut, fromLSQ, complete;
    logic [31:0] pcOut, addressOut, lwData, swDataOut;

    // queue model, slot for slot
    bit          mValid [lsqDepth];
    bit          mStore [lsqDepth];
    bit          mByte [lsqDepth];
    bit          mKnown [lsqDepth];
    bit          mIssued [lsqDepth];
    logic [31:0] mPc [lsqDepth];
    logic [31:0] mAddr [lsqDepth];
    logic [31:0] mData [lsqDepth];
    int          mHead, mTail, mCount;

    bit          expValid, expFwd, expStore, expByte;  // what the DUT shows after this edge
    logic [31:0] expPc, expAddr, expLw, expSw;
    int          errors = 0;
    int          cycles = 0;
    logic [31:0] rngState = 32'd88;
    logic [31:0] nextPc = 32'h0000_1000;   // pcs stay unique, tags never collide

    loadStoreQueue i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] xorshift();
        logic [31:0] x;
        x = rngState;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rngState = x;
        return x;
    endfunction

    // expected issue from model state before the edge, forward first then oldest ready
    function automatic bit refIssue(output int slot, output bit fwd, output logic [31:0] fdata);
        int li, sj, hitSlot, memSlot;
        bit blocked, hit, memSeen;
        slot = 0;
        fwd = 0;
        fdata = '0;
        memSlot = 0;
        memSeen = 0;
        for (int a = 0; a < mCount; a++) begin
            li = (mHead + a) % lsqDepth;
            blocked = 0;
            hit = 0;
            hitSlot = 0;
            for (int b = 0; b < a; b++) begin   // older ones, last match is the youngest
                sj = (mHead + b) % lsqDepth;
                if (mStore[sj] && !mKnown[sj]) blocked = 1;
                else if (mStore[sj] && mAddr[sj] == mAddr[li]) begin
                    hit = 1;
                    hitSlot = sj;
                end
            end
            if (mIssued[li] || !mKnown[li]) continue;
            if (!mStore[li] && !blocked && hit && !mByte[hitSlot]) begin
                slot = li;
                fwd = 1;
                fdata = mData[hitSlot];
                return 1'b1;
            end
            if (!memSeen && (mStore[li] || (!blocked && !hit))) begin
                memSeen = 1;
                memSlot = li;
            end
        end
        slot = memSlot;
        return memSeen;
    endfunction

    task automatic freeSlot(input int s);
        mValid[s]  = 0;
        mKnown[s]  = 0;
        mIssued[s] = 0;
    endtask

    task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] want);
        if (got !== want) begin
            errors++;
            $display("error at %0t ns: %s is %h, expected %h", $time, name, got, want);
        end
    endtask

    // model update, same edge as the DUT
    always @(posedge clk) begin
        int          slot, nRet;
        bit          fwd, full;
        logic [31:0] fdata;
        if (!rstn) begin
            for (int i = 0; i < lsqDepth; i++) freeSlot(i);
            mHead = 0;
            mTail = 0;
            mCount = 0;
            expValid = 0;
            expFwd = 0;
        end else begin
            full     = (mCount == lsqDepth);   // before this edge's retirement
            expValid = refIssue(slot, fwd, fdata);
            expFwd   = expValid && fwd;
            expPc    = mPc[slot];
            expAddr  = mAddr[slot];
            expStore = mStore[slot];
            expByte  = mByte[slot];
            expLw    = expFwd ? fdata : 32'h0;
            expSw    = mStore[slot] ? mData[slot] : 32'h0;
            if (expValid) mIssued[slot] = 1;
            for (int i = 0; i < lsqDepth; i++) begin
                if (addrValid && mValid[i] && mPc[i] == pcLsu) begin
                    mAddr[i]  = addressLsu;
                    mKnown[i] = 1;
                end
            end
            nRet = 0;
            if (retire1 && mValid[mHead] && mPc[mHead] == pcRet1) begin
                nRet = 1;
                if (retire2 && mValid[(mHead + 1) % lsqDepth]
                    && mPc[(mHead + 1) % lsqDepth] == pcRet2) nRet = 2;
            end
            for (int k = 0; k < nRet; k++) freeSlot((mHead + k) % lsqDepth);
            mHead  = (mHead + nRet) % lsqDepth;
            mCount = mCount - nRet;
            if ((memRead || memWrite) && !full) begin   // full queue drops it
                mValid[mTail] = 1;
                mStore[mTail] = memWrite;
                mByte[mTail]  = storeSize;
                mPc[mTail]    = pcDis;
                mData[mTail]  = swData;
                mTail  = (mTail + 1) % lsqDepth;
                mCount = mCount + 1;
            end
        end
    end

    // outputs are settled by the falling edge
    always @(negedge clk) begin
        if (rstn) begin
            checkVal("issueValid", issueValid, expValid);
            checkVal("complete", complete, expFwd);
            checkVal("fromLSQ", fromLSQ, expFwd);
            checkVal("lsqFull", lsqFull, mCount == lsqDepth);
            if (expValid) begin
                checkVal("pcOut", pcOut, expPc);
                checkVal("addressOut", addressOut, expAddr);
                checkVal("loadStore", loadStore, expStore);
                checkVal("storeSizeOut", storeSizeOut, expByte);
                checkVal("lwData", lwData, expLw);
                checkVal("swDataOut", swDataOut, expSw);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycleLimit) begin
            $display("timeout: run still going after %0d cycles", cycles);
            $display("Verification failed");
            $finish;
        end
    end

    task automatic tick();
        @(posedge clk);
        #2;
        {memRead, memWrite, addrValid, retire1, retire2} = '0;   // strobes last one cycle
    endtask

    task automatic dispatchOp(input bit isStore, input bit isByte, input logic [31:0] data,
                              output logic [31:0] pc);
        pc        = nextPc;
        memWrite  = isStore;
        memRead   = !isStore;
        storeSize = isByte;
        pcDis     = nextPc;
        swData    = data;
        nextPc    += 4;
        tick();
    endtask

    task automatic sendAddress(input logic [31:0] pc, input logic [31:0] addr);
        addrValid  = 1;
        pcLsu      = pc;
        addressLsu = addr;
        tick();
    endtask

    // first entry without an address, searched from start
    task automatic broadcastUnknown(input int start, input logic [31:0] addr);
        int s;
        for (int k = 0; k < lsqDepth; k++) begin
            s = (start + k) % lsqDepth;
            if (mValid[s] && !mKnown[s] && !addrValid) begin
                addrValid  = 1;
                pcLsu      = mPc[s];
                addressLsu = addr;
            end
        end
    endtask

    // only heads that already issued are retired
    task automatic setRetire(input bit allowTwo);
        if (mCount > 0 && mIssued[mHead]) begin
            retire1 = 1;
            pcRet1  = mPc[mHead];
            if (allowTwo && mCount > 1 && mIssued[(mHead + 1) % lsqDepth]) begin
                retire2 = 1;
                pcRet2  = mPc[(mHead + 1) % lsqDepth];
            end
        end
    endtask

    task automatic drain();
        while (mCount > 0) begin
            broadcastUnknown(mHead, 32'h1000 | (xorshift() & 32'hC));
            setRetire(1);
            tick();
        end
    endtask

    initial begin
        logic [31:0] p0, p1, p2, p3;
        logic [31:0] pcs [lsqDepth+1];
        logic [31:0] r;
        {memRead, memWrite, storeSize, addrValid, retire1, retire2} = '0;
        {pcDis, swData, pcLsu, addressLsu, pcRet1, pcRet2} = '0;
        rstn = 1'b0;
        repeat (10) @(posedge clk);
        #2 rstn = 1'b1;
        repeat (3) tick();

        // word store then load to it, idle until addresses come
        dispatchOp(1, 0, 32'hA5A5_0001, p0);
        dispatchOp(0, 0, 32'h0, p1);
        repeat (4) tick();
        sendAddress(p0, 32'h100);
        sendAddress(p1, 32'h100);   // forwards once the store address is in
        repeat (3) tick();
        drain();

        // unknown store holds both loads, then forward beats the older memory ops
        dispatchOp(1, 0, 32'h1111_2222, p0);
        dispatchOp(0, 0, 32'h0, p1);
        dispatchOp(1, 0, 32'h3333_4444, p2);
        dispatchOp(0, 0, 32'h0, p3);
        sendAddress(p2, 32'h200);
        sendAddress(p3, 32'h200);
        sendAddress(p1, 32'h300);
        sendAddress(p0, 32'h400);
        repeat (4) tick();
        drain();

        // byte store keeps the load until it retires
        dispatchOp(1, 1, 32'h0000_00EE, p0);
        dispatchOp(0, 0, 32'h0, p1);
        sendAddress(p0, 32'h500);
        sendAddress(p1, 32'h500);
        repeat (6) tick();
        drain();

        // fill up, one dispatch too many, then free two at once
        for (int k = 0; k <= lsqDepth; k++) dispatchOp(0, 0, 32'h0, pcs[k]);
        checkVal("lsqFull", lsqFull, 1);
        sendAddress(pcs[0], 32'h600);
        sendAddress(pcs[1], 32'h604);
        while (!(mIssued[mHead] && mIssued[(mHead + 1) % lsqDepth])) tick();
        setRetire(1);
        tick();
        checkVal("lsqFull", lsqFull, 0);
        dispatchOp(1, 0, 32'h7777_0000, p0);
        drain();

        // random mix, small address pool so matches are common
        for (int c = 0; c < randCycles; c++) begin
            r = xorshift();
            if (r[0]) begin
                memWrite  = r[1];
                memRead   = !r[1];
                storeSize = r[2];
                pcDis     = nextPc;
                swData    = xorshift();
                nextPc    += 4;
            end
            if (r[5:4] != 2'b00) broadcastUnknown(int'(r[11:8]), {28'h1, r[13:12], 2'b00});
            if (r[6]) setRetire(r[7]);
            tick();
        end
        drain();
        repeat (3) tick();

        $display("checks done, %0d errors", errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== verilog/loadStoreQueue.sv ====
`timescale 1ns/1ps

module loadStoreQueue import lsqCfgPkg::*, memOpPkg::*; (
    input  logic             clk,
    input  logic             rstn,
    input  logic             memRead,
    input  logic             memWrite,
    input  logic             storeSize,     // 0 word, 1 byte
    input  logic [pcW-1:0]   pcDis,
    input  logic [dataW-1:0] swData,
    input  logic             addrValid,
    input  logic [pcW-1:0]   pcLsu,
    input  logic [addrW-1:0] addressLsu,
    input  logic             retire1,
    input  logic             retire2,
    input  logic [pcW-1:0]   pcRet1,
    input  logic [pcW-1:0]   pcRet2,
    output logic             lsqFull,
    output logic             issueValid,
    output logic [pcW-1:0]   pcOut,
    output logic [addrW-1:0] addressOut,
    output logic [dataW-1:0] lwData,        // forwarded load data
    output logic [dataW-1:0] swDataOut,
    output logic             loadStore,     // 0 load, 1 store
    output logic             storeSizeOut,
    output logic             fromLSQ,
    output logic             complete       // load finished inside the queue
);

    logic               fwdFound;
    logic [lsqIdxW-1:0] fwdIdx;
    logic [dataW-1:0]   fwdData;
    logic               memFound;
    logic [lsqIdxW-1:0] memIdx;
    issueRecT           issueRec;

    lsqEntryIf entries ();

    lsqStorage uStorage (
        .clk, .rstn, .memRead, .memWrite, .storeSize, .pcDis, .swData,
        .addrValid, .pcLsu, .addressLsu,
        .retire1, .retire2, .pcRet1, .pcRet2,
        .lsqFull,
        .entries (entries.storage)
    );

    storeForward uForward (
        .entries  (entries.search),
        .fwdFound (fwdFound),
        .fwdIdx   (fwdIdx),
        .fwdData  (fwdData)
    );

    readyPick uPick (
        .entries  (entries.search),
        .memFound (memFound),
        .memIdx   (memIdx)
    );

    lsqIssue uIssue (
        .clk, .rstn,
        .entries    (entries.issuer),
        .fwdFound, .fwdIdx, .fwdData,
        .memFound, .memIdx,
        .issueValid (issueValid),
        .issueRec   (issueRec)
    );

    // flatten the issue record for the memory unit and writeback
    assign pcOut        = issueRec.pc;
    assign addressOut   = issueRec.address;
    assign loadStore    = (issueRec.op == memStore);
    assign storeSizeOut = (issueRec.size == accByte);
    assign lwData       = issueRec.forwarded ? issueRec.data : '0;
    assign swDataOut    = (issueRec.op == memStore) ? issueRec.data : '0;
    assign fromLSQ      = issueValid & issueRec.forwarded;
    assign complete     = issueValid & issueRec.forwarded;

endmodule

// ==== verilog/lsqIssue.sv ====
`timescale 1ns/1ps

module lsqIssue import lsqCfgPkg::*, memOpPkg::*; (
    input  logic               clk,
    input  logic               rstn,
    lsqEntryIf.issuer          entries,
    // forwarding search result
    input  logic               fwdFound,
    input  logic [lsqIdxW-1:0] fwdIdx,
    input  logic [dataW-1:0]   fwdData,
    // memory picker result
    input  logic               memFound,
    input  logic [lsqIdxW-1:0] memIdx,
    output logic               issueValid,  // issueRec holds a fresh issue this cycle
    output issueRecT           issueRec
);

    logic [lsqIdxW-1:0] pick;     // slot granted this cycle
    issueRecT           nextRec;

    // a forwarded load needs no memory slot, so it goes first
    assign pick             = fwdFound ? fwdIdx : memIdx;
    assign entries.grant    = fwdFound | memFound;
    assign entries.grantIdx = pick;

    always_comb begin
        nextRec.pc        = entries.pc[pick];
        nextRec.address   = entries.address[pick];
        nextRec.op        = entries.op[pick];
        nextRec.size      = entries.size[pick];
        nextRec.forwarded = fwdFound;
        if (fwdFound) begin
            nextRec.data = fwdData;              // load completes with store data
        end else if (entries.op[pick] == memStore) begin
            nextRec.data = entries.data[pick];
        end else begin
            nextRec.data = '0;                   // memory load, data comes later
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            issueValid <= 1'b0;
        end else begin
            issueValid <= entries.grant;  // one pulse per grant
        end
    end

    // record only meaningful while issueValid is high
    always_ff @(posedge clk) begin
        if (entries.grant) begin
            issueRec <= nextRec;
        end
    end

endmodule

// ==== verilog/readyPick.sv ====
`timescale 1ns/1ps

module readyPick import lsqCfgPkg::*, memOpPkg::*; (
    lsqEntryIf.search          entries,
    output logic               memFound,  // some entry may go to memory
    output logic [lsqIdxW-1:0] memIdx     // oldest of them
);

    always_comb begin
        logic [lsqIdxW-1:0] ei;       // candidate slot
        logic [lsqIdxW-1:0] sj;       // older slot
        logic               hit;      // an older store writes the same address
        logic               blocked;  // an older store still lacks its address
        logic               ready;

        memFound = 1'b0;
        memIdx   = '0;
        ei       = '0;
        sj       = '0;
        hit      = 1'b0;
        blocked  = 1'b0;
        ready    = 1'b0;

        for (int a = 0; a < lsqDepth; a++) begin
            ei      = entries.head + lsqIdxW'(a);
            hit     = 1'b0;
            blocked = 1'b0;

            for (int b = 0; b < a; b++) begin
                sj = entries.head + lsqIdxW'(b);
                if (entries.op[sj] == memStore) begin
                    if (!entries.addrKnown[sj]) begin
                        blocked = 1'b1;
                    end else if (entries.address[sj] == entries.address[ei]) begin
                        hit = 1'b1;
                    end
                end
            end

            // stores go whenever addressed, loads only with no older store in the way
            ready = lsqCntW'(a) < entries.count && entries.valid[ei]
                  && !entries.issued[ei] && entries.addrKnown[ei]
                  && (entries.op[ei] == memStore || (!blocked && !hit));

            if (ready && !memFound) begin
                memFound = 1'b1;
                memIdx   = ei;
            end
        end
    end

endmodule

// ==== verilog/storeForward.sv ====
`timescale 1ns/1ps

module storeForward import lsqCfgPkg::*, memOpPkg::*; (
    lsqEntryIf.search          entries,
    output logic               fwdFound,  // some load can complete from the queue
    output logic [lsqIdxW-1:0] fwdIdx,    // slot of the oldest such load
    output logic [dataW-1:0]   fwdData    // data of its youngest matching store
);

    always_comb begin
        logic [lsqIdxW-1:0] li;       // load slot under test
        logic [lsqIdxW-1:0] sj;       // older slot being scanned
        logic [lsqIdxW-1:0] hitIdx;   // youngest older store to the same address
        logic               hit;
        logic               blocked;  // some older store has no address yet

        fwdFound = 1'b0;
        fwdIdx   = '0;
        fwdData  = '0;
        li       = '0;
        sj       = '0;
        hitIdx   = '0;
        hit      = 1'b0;
        blocked  = 1'b0;

        // walk loads by age so the first hit is the oldest one
        for (int a = 0; a < lsqDepth; a++) begin
            li      = entries.head + lsqIdxW'(a);
            hit     = 1'b0;
            blocked = 1'b0;
            hitIdx  = '0;

            // older entries oldest first, later matches overwrite so hitIdx ends youngest
            for (int b = 0; b < a; b++) begin
                sj = entries.head + lsqIdxW'(b);
                if (entries.op[sj] == memStore) begin
                    if (!entries.addrKnown[sj]) begin
                        blocked = 1'b1;
                    end else if (entries.address[sj] == entries.address[li]) begin
                        hit    = 1'b1;
                        hitIdx = sj;
                    end
                end
            end

            if (!fwdFound && lsqCntW'(a) < entries.count && entries.valid[li]
                && entries.op[li] == memLoad && !entries.issued[li]
                && entries.addrKnown[li] && !blocked && hit
                && entries.size[hitIdx] == accWord) begin
                fwdFound = 1'b1;
                fwdIdx   = li;
                fwdData  = entries.data[hitIdx];   // byte store never gets here
            end
        end
    end

endmodule

// ==== verilog/lsqStorage.sv ====
`timescale 1ns/1ps

module lsqStorage import lsqCfgPkg::*, memOpPkg::*; (
    input  logic             clk,
    input  logic             rstn,
    // dispatch side
    input  logic             memRead,     // load dispatched this cycle
    input  logic             memWrite,    // store dispatched this cycle
    input  logic             storeSize,   // 1 for a byte access
    input  logic [pcW-1:0]   pcDis,
    input  logic [dataW-1:0] swData,
    // address unit broadcast
    input  logic             addrValid,
    input  logic [pcW-1:0]   pcLsu,
    input  logic [addrW-1:0] addressLsu,
    // retirement, two ports, oldest first
    input  logic             retire1,
    input  logic             retire2,
    input  logic [pcW-1:0]   pcRet1,
    input  logic [pcW-1:0]   pcRet2,
    output logic             lsqFull,
    lsqEntryIf.storage       entries
);

    logic [lsqIdxW-1:0] tail;     // next free slot
    logic [lsqIdxW-1:0] nextIdx;  // slot right behind head
    logic               alloc;
    logic               ret1;
    logic               ret2;

    assign lsqFull = (entries.count == lsqCntW'(lsqDepth));
    assign alloc   = (memRead | memWrite) & ~lsqFull;  // full queue drops the dispatch
    assign nextIdx = entries.head + 1'b1;

    // port 1 only ever frees head, port 2 only the entry after it
    assign ret1 = retire1 & entries.valid[entries.head]
                & (entries.pc[entries.head] == pcRet1);
    assign ret2 = ret1 & retire2 & entries.valid[nextIdx]
                & (entries.pc[nextIdx] == pcRet2);

    // payload fields, written on allocate or on address capture
    always_ff @(posedge clk) begin
        for (int i = 0; i < lsqDepth; i++) begin
            if (addrValid && entries.valid[i] && entries.pc[i] == pcLsu) begin
                entries.address[i] <= addressLsu;
            end
        end
        if (alloc) begin
            entries.pc[tail]   <= pcDis;
            entries.op[tail]   <= memWrite ? memStore : memLoad;
            entries.size[tail] <= accSizeT'(storeSize);
            entries.data[tail] <= swData;    // harmless for a load
        end
    end

    // control state
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            entries.valid     <= '0;
            entries.addrKnown <= '0;
            entries.issued    <= '0;
            entries.head      <= '0;
            entries.count     <= '0;
            tail              <= '0;
        end else begin
            // address capture by pc tag
            for (int i = 0; i < lsqDepth; i++) begin
                if (addrValid && entries.valid[i] && entries.pc[i] == pcLsu) begin
                    entries.addrKnown[i] <= 1'b1;
                end
            end

            if (entries.grant) begin
                entries.issued[entries.grantIdx] <= 1'b1;
            end

            // retirement clears after capture and grant so a freed slot stays clean
            if (ret1) begin
                entries.valid[entries.head]     <= 1'b0;
                entries.addrKnown[entries.head] <= 1'b0;
                entries.issued[entries.head]    <= 1'b0;
            end
            if (ret2) begin
                entries.valid[nextIdx]     <= 1'b0;
                entries.addrKnown[nextIdx] <= 1'b0;
                entries.issued[nextIdx]    <= 1'b0;
            end

            // tail never equals a retiring slot, the queue is not full when alloc is high
            if (alloc) begin
                entries.valid[tail]     <= 1'b1;
                entries.addrKnown[tail] <= 1'b0;
                entries.issued[tail]    <= 1'b0;
                tail                    <= tail + 1'b1;
            end

            entries.head  <= entries.head + lsqIdxW'(ret1) + lsqIdxW'(ret2);
            entries.count <= entries.count + lsqCntW'(alloc)
                           - lsqCntW'(ret1) - lsqCntW'(ret2);
        end
    end

endmodule

// ==== verilog/lsqEntryIf.sv ====
`timescale 1ns/1ps

interface lsqEntryIf import lsqCfgPkg::*, memOpPkg::*; ();

    // per-entry state, indexed by physical slot
    logic    [lsqDepth-1:0] valid;
    memOpT   [lsqDepth-1:0] op;
    accSizeT [lsqDepth-1:0] size;
    logic    [lsqDepth-1:0] addrKnown;   // address broadcast already seen
    logic    [lsqDepth-1:0] issued;
    logic [pcW-1:0]   pc      [lsqDepth];
    logic [addrW-1:0] address [lsqDepth];
    logic [dataW-1:0] data    [lsqDepth]; // store data, unused for loads

    // ordering
    logic [lsqIdxW-1:0] head;   // oldest entry, age 0
    logic [lsqCntW-1:0] count;  // live entries from head onward

    // issue grant back to the table
    logic               grant;
    logic [lsqIdxW-1:0] grantIdx;

    modport storage (
        output valid, op, size, addrKnown, issued, pc, address, data, head, count,
        input  grant, grantIdx
    );

    modport search (
        input valid, op, size, addrKnown, issued, address, data, head, count
    );

    modport issuer (
        input  pc, op, size, address, data,
        output grant, grantIdx
    );

endinterface

// ==== verilog/memOpPkg.sv ====
package memOpPkg;

    import lsqCfgPkg::*;

    // kind of memory operation held in an entry
    typedef enum logic {
        memLoad  = 1'b0,
        memStore = 1'b1
    } memOpT;

    // access size, partial words never forward
    typedef enum logic {
        accWord = 1'b0,
        accByte = 1'b1
    } accSizeT;

    // what leaves the queue on an issue
    typedef struct packed {
        logic [pcW-1:0]   pc;
        logic [addrW-1:0] address;
        logic [dataW-1:0] data;       // store data or forwarded load data
        memOpT            op;
        accSizeT          size;
        logic             forwarded;  // load completed inside the queue
    } issueRecT;

endpackage

// ==== verilog/lsqCfgPkg.sv ====
package lsqCfgPkg;

    // queue geometry
    localparam int lsqDepth = 16;           // entries in the circular queue
    localparam int lsqIdxW  = 4;            // bits to index one entry
    localparam int lsqCntW  = lsqIdxW + 1;  // count runs 0..lsqDepth, needs one more bit

    // datapath widths
    localparam int pcW   = 32;   // instruction address, used as the entry tag
    localparam int addrW = 32;   // effective memory address
    localparam int dataW = 32;   // store data and forwarded load data

endpackage
